// ==== source/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

  // operand and result width, fixed by the W forms
  typedef logic [63:0] xlen_t;
  typedef logic [31:0] word_t;

  // one-hot operation selector
  typedef logic [33:0] alu_sel_t;

  // simple operations
  localparam int sel_add    = 0;
  localparam int sel_addw   = 1;
  localparam int sel_sub    = 2;
  localparam int sel_subw   = 3;
  localparam int sel_slt    = 4;
  localparam int sel_sltu   = 5;
  localparam int sel_and    = 6;
  localparam int sel_or     = 7;
  localparam int sel_xor    = 8;
  localparam int sel_sll    = 9;
  localparam int sel_slli   = 10;
  localparam int sel_slliw  = 11;
  localparam int sel_sllw   = 12;
  localparam int sel_srl    = 13;
  localparam int sel_srli   = 14;
  localparam int sel_srliw  = 15;
  localparam int sel_srlw   = 16;
  localparam int sel_sra    = 17;
  localparam int sel_srai   = 18;
  localparam int sel_sraiw  = 19;
  localparam int sel_sraw   = 20;

  // divide group
  localparam int sel_rem    = 21;
  localparam int sel_remu   = 22;
  localparam int sel_remuw  = 23;
  localparam int sel_remw   = 24;
  localparam int sel_div    = 25;
  localparam int sel_divu   = 26;
  localparam int sel_divuw  = 27;
  localparam int sel_divw   = 28;

  // multiply group
  localparam int sel_mul    = 29;
  localparam int sel_mulh   = 30;
  localparam int sel_mulhsu = 31;
  localparam int sel_mulhu  = 32;
  localparam int sel_mulw   = 33;

  typedef enum logic [1:0] {
    unit_int,
    unit_mul,
    unit_div
  } unit_e;

  typedef struct packed {
    logic     valid;
    alu_sel_t sel;
    unit_e    unit;
    xlen_t    op_1;
    xlen_t    op_2;
  } issue_t;

  typedef struct packed {
    logic  done;
    xlen_t data;
  } unit_result_t;

  // W-form results are sign-extended from bit 31
  function automatic xlen_t sext_word(input word_t w);
    return {{32{w[31]}}, w};
  endfunction

endpackage

`default_nettype wire

// ==== source/alu_decode.sv ====
`default_nettype none

module alu_decode (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  alu_pkg::alu_sel_t alu_sel,
  input  alu_pkg::xlen_t    op_1,
  input  alu_pkg::xlen_t    op_2,
  output alu_pkg::issue_t   issue
);

  alu_pkg::unit_e unit_sel;
  logic           is_div;
  logic           is_mul;

  // unit comes from the selector bit groups
  assign is_div = |alu_sel[alu_pkg::sel_divw:alu_pkg::sel_rem];
  assign is_mul = |alu_sel[alu_pkg::sel_mulw:alu_pkg::sel_mul];

  always_comb begin
    unit_sel = alu_pkg::unit_int;
    if (is_div) begin
      unit_sel = alu_pkg::unit_div;
    end
    if (is_mul) begin
      unit_sel = alu_pkg::unit_mul;
    end
  end

  // valid is a single-cycle pulse per operation
  always_ff @(posedge clk) begin
    if (rst) begin
      issue.valid <= 1'b0;
    end else begin
      issue.valid <= in_valid;
    end
  end

  // operation payload, loaded only on a new operation
  always_ff @(posedge clk) begin
    if (in_valid) begin
      issue.sel  <= alu_sel;
      issue.unit <= unit_sel;
      issue.op_1 <= op_1;
      issue.op_2 <= op_2;
    end
  end

  // every strobe names exactly one operation
  a_sel_onehot: assert property (
    @(posedge clk) disable iff (rst)
    in_valid |-> $onehot(alu_sel)
  ) else $error("alu_sel not one-hot with in_valid");

  // the sender has to see alu_stall before issuing behind a long op
  a_no_issue_behind_long: assert property (
    @(posedge clk) disable iff (rst)
    in_valid |-> !(issue.valid && issue.unit != alu_pkg::unit_int)
  ) else $error("in_valid while a multiply or divide sits in issue");

endmodule

`default_nettype wire

// ==== source/alu_int.sv ====
`default_nettype none

module alu_int (
  input  alu_pkg::issue_t       issue,
  output alu_pkg::unit_result_t res
);

  alu_pkg::alu_sel_t sel;
  alu_pkg::xlen_t    op_1;
  alu_pkg::xlen_t    op_2;
  alu_pkg::xlen_t    op_2_in;
  alu_pkg::xlen_t    sum;
  alu_pkg::xlen_t    srl_in;
  alu_pkg::xlen_t    sra_in;
  alu_pkg::xlen_t    sll_out;
  alu_pkg::xlen_t    srl_out;
  alu_pkg::xlen_t    sra_out;
  alu_pkg::xlen_t    data;
  logic              sub_op;
  logic              wide_shift;
  logic              lt_s;
  logic              lt_u;
  logic [5:0]        shamt;

  assign sel  = issue.sel;
  assign op_1 = issue.op_1;
  assign op_2 = issue.op_2;

  // one adder, two's complement for the subtracting ops
  assign sub_op  = sel[alu_pkg::sel_sub] | sel[alu_pkg::sel_subw] |
                   sel[alu_pkg::sel_slt] | sel[alu_pkg::sel_sltu];
  assign op_2_in = sub_op ? ~op_2 : op_2;
  assign sum     = op_1 + op_2_in + {63'b0, sub_op};

  // compare from the sign bits and the difference
  assign lt_s = (op_1[63] & ~op_2[63]) | ((op_1[63] == op_2[63]) & sum[63]);
  assign lt_u = (~op_1[63] & op_2[63]) | ((op_1[63] == op_2[63]) & sum[63]);

  // bit 5 of the amount only for the 64-bit shifts
  assign wide_shift = sel[alu_pkg::sel_sll] | sel[alu_pkg::sel_slli] |
                      sel[alu_pkg::sel_srl] | sel[alu_pkg::sel_srli] |
                      sel[alu_pkg::sel_sra] | sel[alu_pkg::sel_srai];
  assign shamt = {wide_shift & op_2[5], op_2[4:0]};

  // W right shifts see a 32-bit operand in the low half
  assign srl_in = (sel[alu_pkg::sel_srliw] | sel[alu_pkg::sel_srlw]) ?
                  {32'b0, op_1[31:0]} : op_1;
  assign sra_in = (sel[alu_pkg::sel_sraiw] | sel[alu_pkg::sel_sraw]) ?
                  {{32{op_1[31]}}, op_1[31:0]} : op_1;

  assign sll_out = op_1 << shamt;
  assign srl_out = srl_in >> shamt;
  assign sra_out = $signed(sra_in) >>> shamt;

  always_comb begin
    data = '0;
    case (1'b1)
      sel[alu_pkg::sel_add], sel[alu_pkg::sel_sub]:   data = sum;
      sel[alu_pkg::sel_addw], sel[alu_pkg::sel_subw]: data = alu_pkg::sext_word(sum[31:0]);
      sel[alu_pkg::sel_slt]:                          data = {63'b0, lt_s};
      sel[alu_pkg::sel_sltu]:                         data = {63'b0, lt_u};
      sel[alu_pkg::sel_and]:                          data = op_1 & op_2;
      sel[alu_pkg::sel_or]:                           data = op_1 | op_2;
      sel[alu_pkg::sel_xor]:                          data = op_1 ^ op_2;
      sel[alu_pkg::sel_sll], sel[alu_pkg::sel_slli]:  data = sll_out;
      sel[alu_pkg::sel_slliw], sel[alu_pkg::sel_sllw]:
        data = alu_pkg::sext_word(sll_out[31:0]);
      sel[alu_pkg::sel_srl], sel[alu_pkg::sel_srli]:  data = srl_out;
      sel[alu_pkg::sel_srliw], sel[alu_pkg::sel_srlw]:
        data = alu_pkg::sext_word(srl_out[31:0]);
      sel[alu_pkg::sel_sra], sel[alu_pkg::sel_srai]:  data = sra_out;
      sel[alu_pkg::sel_sraiw], sel[alu_pkg::sel_sraw]:
        data = alu_pkg::sext_word(sra_out[31:0]);
      default: data = '0;
    endcase
  end

  assign res.done = issue.valid && (issue.unit == alu_pkg::unit_int);
  assign res.data = data;

endmodule

`default_nettype wire

// ==== source/alu_multiplier.sv ====
`default_nettype none

module alu_multiplier #(
  parameter int mul_step = 1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  alu_pkg::issue_t       issue,
  output logic                  busy,
  output alu_pkg::unit_result_t res
);

  localparam int steps = 64 / mul_step;

  typedef enum logic [1:0] {
    idle,
    run,
    fix
  } state_e;

  state_e              state;
  logic [6:0]          count;
  logic                start;
  logic                a_signed;
  logic                b_signed;
  logic                neg_a;
  logic                neg_b;
  alu_pkg::xlen_t      mag_a;
  alu_pkg::xlen_t      mag_b;
  logic [127:0]        mcand;
  alu_pkg::xlen_t      mplier;
  logic [127:0]        prod;
  logic [127:0]        acc;
  logic [127:0]        prod_fix;
  logic                neg;
  logic                hi_half;
  logic                word;

  assign start = issue.valid && (issue.unit == alu_pkg::unit_mul);

  // mulhu is unsigned on both sides, mulhsu only on op_2
  assign a_signed = ~issue.sel[alu_pkg::sel_mulhu];
  assign b_signed = issue.sel[alu_pkg::sel_mul] | issue.sel[alu_pkg::sel_mulh] |
                    issue.sel[alu_pkg::sel_mulw];
  assign neg_a = a_signed & issue.op_1[63];
  assign neg_b = b_signed & issue.op_2[63];
  assign mag_a = neg_a ? -issue.op_1 : issue.op_1;
  assign mag_b = neg_b ? -issue.op_2 : issue.op_2;

  // mul_step partial products per cycle
  always_comb begin
    acc = prod;
    for (int i = 0; i < mul_step; i++) begin
      if (mplier[i]) begin
        acc = acc + (mcand << i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
      count <= '0;
    end else begin
      case (state)
        idle: begin
          count <= '0;
          if (start) begin
            state <= run;
          end
        end
        run: begin
          count <= count + 7'd1;
          if (count == 7'(steps - 1)) begin
            state <= fix;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      idle: begin
        if (start) begin
          mcand   <= {64'b0, mag_a};
          mplier  <= mag_b;
          prod    <= '0;
          neg     <= neg_a ^ neg_b;
          hi_half <= issue.sel[alu_pkg::sel_mulh] | issue.sel[alu_pkg::sel_mulhsu] |
                     issue.sel[alu_pkg::sel_mulhu];
          word    <= issue.sel[alu_pkg::sel_mulw];
        end
      end
      run: begin
        prod   <= acc;
        mcand  <= mcand << mul_step;
        mplier <= mplier >> mul_step;
      end
      default: ;
    endcase
  end

  // sign back on, then pick the half
  assign prod_fix = neg ? -prod : prod;

  assign busy     = (state != idle);
  assign res.done = (state == fix);
  assign res.data = word    ? alu_pkg::sext_word(prod_fix[31:0]) :
                    hi_half ? prod_fix[127:64] : prod_fix[63:0];

  a_step_divides: assert property (
    @(posedge clk) disable iff (rst)
    (64 % mul_step) == 0
  ) else $error("mul_step must divide 64");

endmodule

`default_nettype wire

// ==== source/alu_divider.sv ====
`default_nettype none

module alu_divider (
  input  logic                  clk,
  input  logic                  rst,
  input  alu_pkg::issue_t       issue,
  output logic                  busy,
  output alu_pkg::unit_result_t res
);

  typedef enum logic [1:0] {
    idle,
    run,
    fix
  } state_e;

  state_e         state;
  logic [5:0]     count;
  logic           start;
  logic           uns;
  logic           word_op;
  logic           rem_op;
  logic           neg_a;
  logic           neg_b;
  logic           zero_div;
  alu_pkg::xlen_t dvnd_ext;
  alu_pkg::xlen_t dvsr_ext;
  alu_pkg::xlen_t mag_a;
  alu_pkg::xlen_t mag_b;
  alu_pkg::xlen_t remd;
  alu_pkg::xlen_t quot;
  alu_pkg::xlen_t dvsr;
  logic [64:0]    shifted;
  logic [64:0]    diff;
  logic           neg_q;
  logic           neg_r;
  logic           is_rem;
  logic           word;
  alu_pkg::xlen_t q_out;
  alu_pkg::xlen_t r_out;
  alu_pkg::xlen_t pick;

  assign start = issue.valid && (issue.unit == alu_pkg::unit_div);

  assign uns = issue.sel[alu_pkg::sel_remu] | issue.sel[alu_pkg::sel_remuw] |
               issue.sel[alu_pkg::sel_divu] | issue.sel[alu_pkg::sel_divuw];
  assign word_op = issue.sel[alu_pkg::sel_remuw] | issue.sel[alu_pkg::sel_remw] |
                   issue.sel[alu_pkg::sel_divuw] | issue.sel[alu_pkg::sel_divw];
  assign rem_op = ~(issue.sel[alu_pkg::sel_div] | issue.sel[alu_pkg::sel_divu] |
                    issue.sel[alu_pkg::sel_divuw] | issue.sel[alu_pkg::sel_divw]);

  // W forms divide the extended low words
  assign dvnd_ext = !word_op ? issue.op_1 :
                    uns ? {32'b0, issue.op_1[31:0]} : alu_pkg::sext_word(issue.op_1[31:0]);
  assign dvsr_ext = !word_op ? issue.op_2 :
                    uns ? {32'b0, issue.op_2[31:0]} : alu_pkg::sext_word(issue.op_2[31:0]);

  assign neg_a    = ~uns & dvnd_ext[63];
  assign neg_b    = ~uns & dvsr_ext[63];
  assign mag_a    = neg_a ? -dvnd_ext : dvnd_ext;
  assign mag_b    = neg_b ? -dvsr_ext : dvsr_ext;
  assign zero_div = (dvsr_ext == '0);

  // one restoring step: shift in the next dividend bit, try subtract
  assign shifted = {remd, quot[63]};
  assign diff    = shifted - {1'b0, dvsr};

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
      count <= '0;
    end else begin
      case (state)
        idle: begin
          count <= '0;
          if (start) begin
            state <= zero_div ? fix : run;
          end
        end
        run: begin
          count <= count + 6'd1;
          if (count == 6'd63) begin
            state <= fix;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      idle: begin
        if (start) begin
          is_rem <= rem_op;
          word   <= word_op;
          dvsr   <= mag_b;
          if (zero_div) begin
            // quotient all ones, remainder is the dividend
            quot  <= '1;
            remd  <= dvnd_ext;
            neg_q <= 1'b0;
            neg_r <= 1'b0;
          end else begin
            quot  <= mag_a;
            remd  <= '0;
            neg_q <= neg_a ^ neg_b;
            neg_r <= neg_a;
          end
        end
      end
      run: begin
        if (!diff[64]) begin
          remd <= diff[63:0];
          quot <= {quot[62:0], 1'b1};
        end else begin
          remd <= shifted[63:0];
          quot <= {quot[62:0], 1'b0};
        end
      end
      default: ;
    endcase
  end

  // remainder follows the dividend sign
  assign q_out = neg_q ? -quot : quot;
  assign r_out = neg_r ? -remd : remd;
  assign pick  = is_rem ? r_out : q_out;

  assign busy     = (state != idle);
  assign res.done = (state == fix);
  assign res.data = word ? alu_pkg::sext_word(pick[31:0]) : pick;

endmodule

`default_nettype wire

// ==== source/alu_result.sv ====
`default_nettype none

module alu_result (
  input  logic                  clk,
  input  logic                  rst,
  input  alu_pkg::issue_t       issue,
  input  alu_pkg::unit_result_t int_res,
  input  alu_pkg::unit_result_t mul_res,
  input  alu_pkg::unit_result_t div_res,
  input  logic                  mul_busy,
  input  logic                  div_busy,
  input  logic                  lsu_stall,
  output logic                  alu_ok,
  output logic                  alu_stall,
  output alu_pkg::xlen_t        result
);

  logic           done_any;
  logic           free;
  logic           skid_valid;
  alu_pkg::xlen_t skid_data;
  alu_pkg::xlen_t done_data;

  assign done_any  = int_res.done | mul_res.done | div_res.done;
  assign done_data = int_res.done ? int_res.data :
                     mul_res.done ? mul_res.data : div_res.data;

  // output register empty or being taken this cycle
  assign free = !alu_ok || !lsu_stall;

  // spare slot catches the op already in issue when lsu_stall rises
  always_ff @(posedge clk) begin
    if (rst) begin
      alu_ok     <= 1'b0;
      skid_valid <= 1'b0;
    end else if (free) begin
      alu_ok     <= skid_valid | done_any;
      skid_valid <= skid_valid & done_any;
    end else begin
      skid_valid <= skid_valid | done_any;
    end
  end

  always_ff @(posedge clk) begin
    if (free) begin
      if (skid_valid) begin
        result    <= skid_data;
        skid_data <= done_data;
      end else if (done_any) begin
        result <= done_data;
      end
    end else if (done_any) begin
      skid_data <= done_data;
    end
  end

  assign alu_stall = (issue.valid && issue.unit != alu_pkg::unit_int) |
                     mul_busy | div_busy | (alu_ok & lsu_stall);

  a_one_done: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0({int_res.done, mul_res.done, div_res.done})
  ) else $error("more than one unit finished in the same cycle");

  // both slots full and held means a new result would be lost
  a_no_overrun: assert property (
    @(posedge clk) disable iff (rst)
    (done_any && skid_valid) |-> !lsu_stall
  ) else $error("result finished while the held results were not accepted");

endmodule

`default_nettype wire

// ==== source/alu_top.sv ====
`default_nettype none

module alu_top #(
  parameter int mul_step = 1
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  alu_pkg::alu_sel_t alu_sel,
  input  alu_pkg::xlen_t    op_1,
  input  alu_pkg::xlen_t    op_2,
  input  logic              lsu_stall,
  output logic              alu_stall,
  output logic              alu_ok,
  output alu_pkg::xlen_t    result
);

  alu_pkg::issue_t       issue;
  alu_pkg::unit_result_t int_res;
  alu_pkg::unit_result_t mul_res;
  alu_pkg::unit_result_t div_res;
  logic                  mul_busy;
  logic                  div_busy;

  alu_decode alu_decode_i (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .alu_sel  (alu_sel),
    .op_1     (op_1),
    .op_2     (op_2),
    .issue    (issue)
  );

  alu_int alu_int_i (
    .issue (issue),
    .res   (int_res)
  );

  alu_multiplier #(
    .mul_step (mul_step)
  ) alu_multiplier_i (
    .clk   (clk),
    .rst   (rst),
    .issue (issue),
    .busy  (mul_busy),
    .res   (mul_res)
  );

  alu_divider alu_divider_i (
    .clk   (clk),
    .rst   (rst),
    .issue (issue),
    .busy  (div_busy),
    .res   (div_res)
  );

  alu_result alu_result_i (
    .clk       (clk),
    .rst       (rst),
    .issue     (issue),
    .int_res   (int_res),
    .mul_res   (mul_res),
    .div_res   (div_res),
    .mul_busy  (mul_busy),
    .div_busy  (div_busy),
    .lsu_stall (lsu_stall),
    .alu_ok    (alu_ok),
    .alu_stall (alu_stall),
    .result    (result)
  );

endmodule

`default_nettype wire

// ==== testbench/alu_checker.sv ====
`default_nettype none

module alu_checker (
  input  logic           clk,
  input  logic           rst,
  input  logic           in_valid,
  input  alu_pkg::xlen_t exp_value,
  input  logic           exp_long,
  input  logic           lat_check,
  input  logic           lsu_stall,
  input  logic           alu_stall,
  input  logic           alu_ok,
  input  alu_pkg::xlen_t result,
  output int             error_count,
  output int             accept_count,
  output int             pending
);
  timeunit 1ns;
  timeprecision 1ps;

  alu_pkg::xlen_t exp_q[$];
  int             cyc_q[$];
  logic           long_q[$];
  alu_pkg::xlen_t held_data;
  alu_pkg::xlen_t want;
  logic           held;
  logic           long_open;
  int             cycle;
  int             issued_at;

  always @(posedge clk) begin
    if (rst) begin
      error_count  = 0;
      accept_count = 0;
      pending      = 0;
      held         = 1'b0;
      held_data    = '0;
      long_open    = 1'b0;
      cycle        = 0;
      exp_q.delete();
      cyc_q.delete();
      long_q.delete();
    end else begin
      cycle = cycle + 1;

      // a result held under lsu_stall must not move
      if (held) begin
        if (!alu_ok) begin
          $display("alu_ok dropped at %0d ns while a result was still held", $time);
          error_count++;
        end else if (result !== held_data) begin
          $display("mismatch at %0d ns: result held %h, got %h", $time, held_data, result);
          error_count++;
        end
      end

      // a multiply or divide holds off new operations until its result is taken
      if (long_open && !(alu_ok && !lsu_stall) && (alu_stall !== 1'b1)) begin
        $display("mismatch at %0d ns: alu_stall expected 1, got %b", $time, alu_stall);
        error_count++;
      end

      // accepted result, oldest expectation first
      if (alu_ok && !lsu_stall) begin
        accept_count++;
        if (exp_q.size() == 0) begin
          $display("result accepted with empty queue at %0d ns", $time);
          error_count++;
        end else begin
          want      = exp_q.pop_front();
          issued_at = cyc_q.pop_front();
          if (long_q.pop_front()) begin
            long_open = 1'b0;
          end
          if (result !== want) begin
            $display("mismatch at %0d ns: result expected %h, got %h", $time, want, result);
            error_count++;
          end
          if (lat_check && (cycle - issued_at != 2)) begin
            $display("result at %0d ns came %0d cycles after its operation instead of 2",
                     $time, cycle - issued_at);
            error_count++;
          end
        end
      end

      held      = alu_ok && lsu_stall;
      held_data = result;

      if (in_valid) begin
        exp_q.push_back(exp_value);
        cyc_q.push_back(cycle);
        long_q.push_back(exp_long);
        if (exp_long) begin
          long_open = 1'b1;
        end
      end
      pending = exp_q.size();
    end
  end

endmodule

`default_nettype wire

// ==== testbench/alu_tb.sv ====
`default_nettype none

module alu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period  = 100;
  localparam int n_arith_dir = 9 * 6 * 6;
  localparam int n_arith_rnd = 200;
  localparam int n_shift     = 12 * 4 * 3;
  localparam int n_mul       = 5 * (20 + 16);
  localparam int n_div       = 8 * (12 + 7);
  localparam int n_bp        = 150;
  localparam int n_b2b       = 100;
  localparam int total_ops   = n_arith_dir + n_arith_rnd + n_shift + n_mul + n_div +
                               n_bp + n_b2b;
  localparam int watchdog_cycles = total_ops * 80 + 2000;

  logic              clk;
  logic              rst;
  logic              in_valid;
  alu_pkg::alu_sel_t alu_sel;
  alu_pkg::xlen_t    op_1;
  alu_pkg::xlen_t    op_2;
  logic              lsu_stall;
  logic              alu_stall;
  logic              alu_ok;
  alu_pkg::xlen_t    result;
  alu_pkg::xlen_t    exp_value;
  logic              exp_long;
  logic              lat_check;
  int                error_count;
  int                accept_count;
  int                pending;
  logic [15:0]       lfsr_state;
  logic              bp_mode;
  int                issued;
  int                errors_seen;
  int                tb_errors;

  alu_top #(
    .mul_step (2)
  ) alu_top_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .alu_sel   (alu_sel),
    .op_1      (op_1),
    .op_2      (op_2),
    .lsu_stall (lsu_stall),
    .alu_stall (alu_stall),
    .alu_ok    (alu_ok),
    .result    (result)
  );

  alu_checker alu_checker_i (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .exp_value    (exp_value),
    .exp_long     (exp_long),
    .lat_check    (lat_check),
    .lsu_stall    (lsu_stall),
    .alu_stall    (alu_stall),
    .alu_ok       (alu_ok),
    .result       (result),
    .error_count  (error_count),
    .accept_count (accept_count),
    .pending      (pending)
  );

  always #(clk_period / 2) clk = ~clk;

  // 16-bit Galois LFSR, one step per bit
  function automatic logic rand_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 16'hb400;
    end
    return out;
  endfunction

  function automatic alu_pkg::xlen_t rand_bits(input int n);
    alu_pkg::xlen_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[62:0], rand_bit()};
    end
    return r;
  endfunction

  function automatic alu_pkg::xlen_t sext32(input alu_pkg::word_t w);
    return {{32{w[31]}}, w};
  endfunction

  // zero, all ones, most negative, most positive, 32-bit wrap points
  function automatic alu_pkg::xlen_t edge_value(input int k);
    case (k)
      0:       return 64'h0000_0000_0000_0000;
      1:       return 64'hffff_ffff_ffff_ffff;
      2:       return 64'h8000_0000_0000_0000;
      3:       return 64'h7fff_ffff_ffff_ffff;
      4:       return 64'h0000_0000_7fff_ffff;
      default: return 64'h0000_0000_ffff_ffff;
    endcase
  endfunction

  function automatic alu_pkg::xlen_t shift_amount(input int k);
    case (k)
      0:       return 64'd0;
      1:       return 64'd31;
      2:       return 64'd32;
      default: return 64'd63;
    endcase
  endfunction

  // zero divisor, overflow and sign cases as {dividend, divisor}
  function automatic logic [127:0] div_pair(input int k);
    case (k)
      0:       return {64'h0000_0001_2345_6789, 64'h0};
      1:       return {64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff};
      2:       return {64'h5555_5555_8000_0000, 64'hffff_ffff_ffff_ffff};
      3:       return {64'hffff_ffff_ffff_fff9, 64'h0000_0000_0000_0002};
      4:       return {64'h0000_0000_0000_0007, 64'hffff_ffff_ffff_fffe};
      5:       return {64'hffff_ffff_ffff_fff9, 64'hffff_ffff_ffff_fffe};
      default: return {64'hffff_ffff_0000_0005, 64'h0000_0001_0000_0000};
    endcase
  endfunction

  function automatic alu_pkg::xlen_t alu_ref(input int idx, input alu_pkg::xlen_t a,
                                             input alu_pkg::xlen_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] wa;
    logic signed [31:0] wb;
    logic [127:0]       prod;
    logic               ovf;
    logic               wovf;
    alu_pkg::xlen_t     r;
    sa   = a;
    sb   = b;
    wa   = a[31:0];
    wb   = b[31:0];
    ovf  = (a == 64'h8000_0000_0000_0000) && (b == 64'hffff_ffff_ffff_ffff);
    wovf = (a[31:0] == 32'h8000_0000) && (b[31:0] == 32'hffff_ffff);
    r    = '0;
    case (idx)
      alu_pkg::sel_add:    r = a + b;
      alu_pkg::sel_sub:    r = a - b;
      alu_pkg::sel_addw:   r = sext32(a[31:0] + b[31:0]);
      alu_pkg::sel_subw:   r = sext32(a[31:0] - b[31:0]);
      alu_pkg::sel_slt:    r = {63'b0, sa < sb};
      alu_pkg::sel_sltu:   r = {63'b0, a < b};
      alu_pkg::sel_and:    r = a & b;
      alu_pkg::sel_or:     r = a | b;
      alu_pkg::sel_xor:    r = a ^ b;
      alu_pkg::sel_sll, alu_pkg::sel_slli:   r = a << b[5:0];
      alu_pkg::sel_slliw, alu_pkg::sel_sllw: r = sext32(a[31:0] << b[4:0]);
      alu_pkg::sel_srl, alu_pkg::sel_srli:   r = a >> b[5:0];
      alu_pkg::sel_srliw, alu_pkg::sel_srlw: r = sext32(a[31:0] >> b[4:0]);
      alu_pkg::sel_sra, alu_pkg::sel_srai:   r = sa >>> b[5:0];
      alu_pkg::sel_sraiw, alu_pkg::sel_sraw: r = sext32(wa >>> b[4:0]);
      alu_pkg::sel_mul:    r = a * b;
      alu_pkg::sel_mulh: begin
        prod = {{64{a[63]}}, a} * {{64{b[63]}}, b};
        r    = prod[127:64];
      end
      alu_pkg::sel_mulhsu: begin
        prod = {{64{a[63]}}, a} * {64'b0, b};
        r    = prod[127:64];
      end
      alu_pkg::sel_mulhu: begin
        prod = {64'b0, a} * {64'b0, b};
        r    = prod[127:64];
      end
      alu_pkg::sel_mulw:   r = sext32(a[31:0] * b[31:0]);
      alu_pkg::sel_div: begin
        if (b == '0) begin
          r = '1;
        end else if (ovf) begin
          r = a;
        end else begin
          r = sa / sb;
        end
      end
      alu_pkg::sel_divu:   r = (b == '0) ? '1 : a / b;
      alu_pkg::sel_rem: begin
        if (b == '0) begin
          r = a;
        end else if (ovf) begin
          r = '0;
        end else begin
          r = sa % sb;
        end
      end
      alu_pkg::sel_remu:   r = (b == '0) ? a : a % b;
      alu_pkg::sel_divw:
        r = (wb == '0) ? '1 : wovf ? sext32(a[31:0]) : sext32(wa / wb);
      alu_pkg::sel_divuw:
        r = (b[31:0] == '0) ? '1 : sext32(a[31:0] / b[31:0]);
      alu_pkg::sel_remw:
        r = (wb == '0) ? sext32(a[31:0]) : wovf ? '0 : sext32(wa % wb);
      alu_pkg::sel_remuw:
        r = (b[31:0] == '0) ? sext32(a[31:0]) : sext32(a[31:0] % b[31:0]);
      default: r = '0;
    endcase
    return r;
  endfunction

  // waits for a cycle with alu_stall low, then strobes the operation
  task automatic issue_op(input int idx, input alu_pkg::xlen_t a, input alu_pkg::xlen_t b);
    logic sent;
    sent = 1'b0;
    while (!sent) begin
      @(posedge clk);
      #1;
      in_valid  = 1'b0;
      lsu_stall = bp_mode ? rand_bit() : 1'b0;
      #1;
      if (!alu_stall) begin
        in_valid  = 1'b1;
        alu_sel   = alu_pkg::alu_sel_t'(1) << idx;
        op_1      = a;
        op_2      = b;
        exp_value = alu_ref(idx, a, b);
        // divide and multiply groups sit above the simple ops
        exp_long  = (idx >= alu_pkg::sel_rem);
        issued++;
        sent = 1'b1;
      end
    end
  endtask

  task automatic drain_results();
    do begin
      @(posedge clk);
      #1;
      in_valid  = 1'b0;
      lsu_stall = bp_mode ? rand_bit() : 1'b0;
    end while (pending != 0);
    lsu_stall = 1'b0;
  endtask

  task automatic finish_test(input string name);
    drain_results();
    $display("test %s: %0d errors", name, error_count - errors_seen);
    errors_seen = error_count;
  endtask

  initial begin : stimulus
    alu_pkg::xlen_t a;
    alu_pkg::xlen_t b;
    logic [127:0]   pair;
    int             idx;
    clk         = 1'b0;
    rst         = 1'b1;
    in_valid    = 1'b0;
    alu_sel     = '0;
    op_1        = '0;
    op_2        = '0;
    lsu_stall   = 1'b0;
    exp_value   = '0;
    exp_long    = 1'b0;
    lat_check   = 1'b0;
    bp_mode     = 1'b0;
    issued      = 0;
    errors_seen = 0;
    tb_errors   = 0;
    lfsr_state  = 16'd57590;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    for (idx = alu_pkg::sel_add; idx <= alu_pkg::sel_xor; idx++) begin
      for (int i = 0; i < 6; i++) begin
        for (int j = 0; j < 6; j++) begin
          issue_op(idx, edge_value(i), edge_value(j));
        end
      end
    end
    for (int n = 0; n < n_arith_rnd; n++) begin
      idx = int'(rand_bits(4) % 9);
      a   = rand_bits(64);
      b   = rand_bits(64);
      issue_op(idx, a, b);
    end
    finish_test("arith_logic");

    // junk above the amount field must be ignored
    for (idx = alu_pkg::sel_sll; idx <= alu_pkg::sel_sraw; idx++) begin
      for (int j = 0; j < 4; j++) begin
        for (int k = 0; k < 3; k++) begin
          a = (k == 0) ? 64'h1234_5678_9abc_def0 :
              (k == 1) ? 64'hffff_ffff_7fff_ffff : rand_bits(64);
          b = (rand_bits(64) & ~64'h3f) | shift_amount(j);
          issue_op(idx, a, b);
        end
      end
    end
    finish_test("shifts");

    for (idx = alu_pkg::sel_mul; idx <= alu_pkg::sel_mulw; idx++) begin
      for (int n = 0; n < 20; n++) begin
        a = rand_bits(64);
        b = rand_bits(64);
        issue_op(idx, a, b);
      end
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          issue_op(idx, edge_value(i), edge_value(j));
        end
      end
    end
    finish_test("multiply");

    for (idx = alu_pkg::sel_rem; idx <= alu_pkg::sel_divw; idx++) begin
      for (int n = 0; n < 12; n++) begin
        a = rand_bits(64);
        b = rand_bits(64) >> rand_bits(6);
        issue_op(idx, a, b);
      end
      for (int k = 0; k < 7; k++) begin
        pair = div_pair(k);
        issue_op(idx, pair[127:64], pair[63:0]);
      end
    end
    finish_test("divide");

    bp_mode = 1'b1;
    for (int n = 0; n < n_bp; n++) begin
      idx = int'(rand_bits(6) % 34);
      a   = rand_bits(64);
      b   = rand_bits(64);
      issue_op(idx, a, b);
    end
    finish_test("back_pressure");
    bp_mode = 1'b0;

    // simple ops only, one per cycle
    lat_check = 1'b1;
    for (int n = 0; n < n_b2b; n++) begin
      idx = int'(rand_bits(5) % 21);
      a   = rand_bits(64);
      b   = rand_bits(64);
      issue_op(idx, a, b);
    end
    finish_test("back_to_back");
    lat_check = 1'b0;

    if (accept_count != issued) begin
      $display("%0d results accepted for %0d issued operations", accept_count, issued);
      tb_errors++;
    end
    $display("summary: %0d issued, %0d accepted, %0d failed checks",
             issued, accept_count, error_count + tb_errors);
    if (error_count + tb_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchdog_cycles * clk_period);
    $display("timeout after %0d cycles with %0d results outstanding", watchdog_cycles, pending);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/alu_pkg.sv
source/alu_decode.sv
source/alu_int.sv
source/alu_multiplier.sv
source/alu_divider.sv
source/alu_result.sv
source/alu_top.sv
testbench/alu_checker.sv
testbench/alu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f verilog.f --top-module alu_tb \
  --Mdir obj_dir -o alu_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/alu_tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "No errors" "$log"; then
  exit 0
fi
exit 1
